// ==== src/csr_config_pkg.sv ====
`default_nettype none

package csr_config_pkg;

    // ------------------------------
    // Datapath widths
    // ------------------------------
    // Byte address of a CSR element
    localparam int addr_width = 32;
    // Vertex index and range count
    localparam int index_width = 16;
    // Word returned by a memory read
    localparam int data_width = 32;

    // ------------------------------
    // FIFO defaults
    // ------------------------------
    localparam int fifo_depth_default = 16;
    // Leaves room for words already in flight when ready drops
    localparam int prog_thresh_default = 12;

    // Destination code carried on every memory response
    typedef enum logic {
        dest_config    = 1'b0,
        dest_generator = 1'b1
    } dest_t;

    // Tag values that pick the word inside a config response
    localparam logic [index_width-1:0] config_tag_base = 16'd0;
    localparam logic [index_width-1:0] config_tag_stride = 16'd1;

    // Permanent memory configuration seen by the generator
    typedef struct packed {
        logic [addr_width-1:0]  base;
        logic [index_width-1:0] stride;
        logic                   loaded;
    } csr_config_t;

endpackage

`default_nettype wire

// ==== src/csr_packet_pkg.sv ====
`default_nettype none

package csr_packet_pkg;

    import csr_config_pkg::*;

    // ------------------------------
    // Engine stream
    // ------------------------------
    // Request: start index plus count of entries
    // Result: start holds the echoed index, count is zero
    typedef struct packed {
        logic                   valid;
        logic [index_width-1:0] start;
        logic [index_width-1:0] count;
        logic [data_width-1:0]  data;
    } engine_packet_t;

    // ------------------------------
    // Memory streams
    // ------------------------------
    // Read request, the tag travels back with the data
    typedef struct packed {
        logic                   valid;
        logic [addr_width-1:0]  addr;
        logic [index_width-1:0] tag;
    } mem_request_t;

    // Read response
    // Dest picks the consumer inside the engine
    typedef struct packed {
        logic                   valid;
        dest_t                  dest;
        logic [index_width-1:0] tag;
        logic [data_width-1:0]  data;
    } mem_response_t;

endpackage

`default_nettype wire

// ==== src/csr_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_fifo import csr_config_pkg::*, csr_packet_pkg::*; #(
    parameter type payload_t   = engine_packet_t,
    parameter int  fifo_depth  = fifo_depth_default,
    parameter int  prog_thresh = prog_thresh_default
) (
    input  logic     ap_clk,
    input  logic     reset,
    input  payload_t in_data,
    output logic     in_ready,
    output payload_t out_data,
    input  logic     out_ready,
    output logic     empty
);

    localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int count_width = $clog2(fifo_depth + 1);

    // Storage, payload only
    payload_t mem [fifo_depth];

    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   push;
    logic                   pop;

    // Wrap at depth, which need not be a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    // Programmable full stands in for ready
    assign in_ready = (count < count_width'(prog_thresh));
    assign push = in_data.valid & in_ready;
    assign pop = out_data.valid & out_ready;

    // Head entry, valid while anything is stored
    always_comb begin
        out_data = mem[rd_ptr];
        out_data.valid = ~empty;
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/csr_response_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_response_router import csr_config_pkg::*, csr_packet_pkg::*; (
    input  logic          ap_clk,
    input  logic          reset,
    input  mem_response_t response_in,
    output logic          response_ready,
    output mem_response_t config_response,
    output mem_response_t gen_response,
    input  logic          gen_ready
);

    // One-entry holding register
    mem_response_t resp_q;
    logic          to_config;
    logic          out_fire;
    logic          load;

    assign to_config = (resp_q.dest == dest_config);
    // Config side never stalls, generator side waits on its ready
    assign out_fire = resp_q.valid & (to_config | gen_ready);
    // Refill in the same cycle the held word leaves
    assign response_ready = ~resp_q.valid | out_fire;
    assign load = response_in.valid & response_ready;

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            resp_q.valid <= 1'b0;
        end else if (load) begin
            resp_q <= response_in;
        end else if (out_fire) begin
            resp_q.valid <= 1'b0;
        end
    end

    // ------------------------------
    // Steer by dest field
    // ------------------------------
    always_comb begin
        config_response = resp_q;
        config_response.valid = resp_q.valid & to_config;
        gen_response = resp_q;
        gen_response.valid = resp_q.valid & ~to_config;
    end

endmodule

`default_nettype wire

// ==== src/csr_configure_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_configure_memory import csr_config_pkg::*, csr_packet_pkg::*; (
    input  logic          ap_clk,
    input  logic          reset,
    input  mem_response_t config_response,
    output csr_config_t   csr_config
);

    logic [addr_width-1:0]  base_q;
    logic [index_width-1:0] stride_q;
    logic                   have_base;
    logic                   have_stride;
    logic                   loaded_q;
    logic                   take;

    // Words after loaded are ignored, config is permanent
    assign take = config_response.valid & (config_response.dest == dest_config) & ~loaded_q;

    // Config words
    always_ff @(posedge ap_clk) begin
        if (take && config_response.tag == config_tag_base) begin
            base_q <= addr_width'(config_response.data);
        end
        if (take && config_response.tag == config_tag_stride) begin
            stride_q <= config_response.data[index_width-1:0];
        end
    end

    // ------------------------------
    // Arrival tracking
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            have_base   <= 1'b0;
            have_stride <= 1'b0;
            loaded_q    <= 1'b0;
        end else begin
            if (take && config_response.tag == config_tag_base) begin
                have_base <= 1'b1;
            end
            if (take && config_response.tag == config_tag_stride) begin
                have_stride <= 1'b1;
            end
            // One cycle after the second word, then sticky
            loaded_q <= loaded_q | (have_base & have_stride);
        end
    end

    assign csr_config.base = base_q;
    assign csr_config.stride = stride_q;
    assign csr_config.loaded = loaded_q;

endmodule

`default_nettype wire

// ==== src/csr_index_generator.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_index_generator import csr_config_pkg::*, csr_packet_pkg::*; (
    input  logic           ap_clk,
    input  logic           reset,
    input  csr_config_t    csr_config,
    input  engine_packet_t engine_req,
    output logic           engine_req_ready,
    output mem_request_t   mem_request,
    input  logic           mem_request_ready,
    input  mem_response_t  gen_response,
    output logic           gen_ready,
    output engine_packet_t engine_out,
    input  logic           engine_out_ready,
    output logic           idle
);

    // Range walker state
    logic                   busy;
    logic [index_width-1:0] cur_index;
    logic [index_width-1:0] remaining;
    logic [addr_width-1:0]  addr_acc;

    // Reads issued and not yet answered
    logic [index_width:0]   outstanding;

    engine_packet_t result_q;
    logic           take_req;
    logic           issue;
    logic           take_resp;

    // New range only once configured and the last one is walked
    assign engine_req_ready = csr_config.loaded & ~busy;
    assign take_req = engine_req.valid & engine_req_ready;
    assign issue = mem_request.valid & mem_request_ready;

    // Output register frees up when downstream takes it
    assign gen_ready = ~result_q.valid | engine_out_ready;
    assign take_resp = gen_response.valid & gen_ready;

    // ------------------------------
    // Index generation
    // ------------------------------
    always_comb begin
        mem_request.valid = busy;
        mem_request.addr = addr_acc;
        mem_request.tag = cur_index;
    end

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (take_req) begin
            // Zero count retires the packet with no reads
            busy      <= (engine_req.count != '0);
            cur_index <= engine_req.start;
            remaining <= engine_req.count;
            addr_acc  <= csr_config.base
                         + addr_width'(engine_req.start) * addr_width'(csr_config.stride);
        end else if (issue) begin
            busy      <= (remaining != index_width'(1));
            cur_index <= cur_index + 1'b1;
            remaining <= remaining - 1'b1;
            // Next element is one stride further
            addr_acc  <= addr_acc + addr_width'(csr_config.stride);
        end
    end

    // Up on issue, down on response
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            outstanding <= '0;
        end else if (issue && !take_resp) begin
            outstanding <= outstanding + 1'b1;
        end else if (take_resp && !issue) begin
            outstanding <= outstanding - 1'b1;
        end
    end

    // ------------------------------
    // Response to result packet
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            result_q.valid <= 1'b0;
        end else if (take_resp) begin
            result_q.valid <= 1'b1;
            // Tag is the index that was read
            result_q.start <= gen_response.tag;
            result_q.count <= '0;
            result_q.data  <= gen_response.data;
        end else if (engine_out_ready) begin
            result_q.valid <= 1'b0;
        end
    end

    assign engine_out = result_q;
    assign idle = ~busy & (outstanding == '0) & ~result_q.valid;

endmodule

`default_nettype wire

// ==== src/engine_csr_index.sv ====
`timescale 1ns/100ps
`default_nettype none

module engine_csr_index import csr_config_pkg::*, csr_packet_pkg::*; #(
    parameter int fifo_depth  = fifo_depth_default,
    parameter int prog_thresh = prog_thresh_default
) (
    input  logic           ap_clk,
    input  logic           areset_csr_engine,
    input  engine_packet_t engine_in,
    output logic           engine_in_ready,
    input  mem_response_t  mem_response_in,
    output logic           mem_response_ready,
    output mem_request_t   mem_request_out,
    input  logic           mem_request_ready,
    output engine_packet_t engine_out,
    input  logic           engine_out_ready,
    output logic           done
);

    // ------------------------------
    // Reset copies
    // ------------------------------
    logic reset_top;
    logic reset_engine_fifo;
    logic reset_request_fifo;
    logic reset_router;
    logic reset_config;
    logic reset_generator;

    always_ff @(posedge ap_clk) begin
        reset_top          <= areset_csr_engine;
        reset_engine_fifo  <= areset_csr_engine;
        reset_request_fifo <= areset_csr_engine;
        reset_router       <= areset_csr_engine;
        reset_config       <= areset_csr_engine;
        reset_generator    <= areset_csr_engine;
    end

    // Internal streams
    engine_packet_t engine_req;
    logic           engine_req_ready;
    mem_request_t   gen_request;
    logic           gen_request_ready;
    mem_response_t  config_response;
    mem_response_t  gen_response;
    logic           gen_ready;
    engine_packet_t gen_result;
    logic           gen_result_ready;
    csr_config_t    csr_config;
    logic           gen_idle;
    logic           engine_fifo_empty;
    logic           request_fifo_empty;

    // Engine packets wait here until the generator is free
    csr_fifo #(
        .payload_t  (engine_packet_t),
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) u_engine_fifo (
        .ap_clk   (ap_clk),
        .reset    (reset_engine_fifo),
        .in_data  (engine_in),
        .in_ready (engine_in_ready),
        .out_data (engine_req),
        .out_ready(engine_req_ready),
        .empty    (engine_fifo_empty)
    );

    csr_response_router u_router (
        .ap_clk         (ap_clk),
        .reset          (reset_router),
        .response_in    (mem_response_in),
        .response_ready (mem_response_ready),
        .config_response(config_response),
        .gen_response   (gen_response),
        .gen_ready      (gen_ready)
    );

    csr_configure_memory u_configure_memory (
        .ap_clk         (ap_clk),
        .reset          (reset_config),
        .config_response(config_response),
        .csr_config     (csr_config)
    );

    csr_index_generator u_generator (
        .ap_clk           (ap_clk),
        .reset            (reset_generator),
        .csr_config       (csr_config),
        .engine_req       (engine_req),
        .engine_req_ready (engine_req_ready),
        .mem_request      (gen_request),
        .mem_request_ready(gen_request_ready),
        .gen_response     (gen_response),
        .gen_ready        (gen_ready),
        .engine_out       (gen_result),
        .engine_out_ready (gen_result_ready),
        .idle             (gen_idle)
    );

    // Absorbs memory back-pressure, threshold pauses generation
    csr_fifo #(
        .payload_t  (mem_request_t),
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) u_request_fifo (
        .ap_clk   (ap_clk),
        .reset    (reset_request_fifo),
        .in_data  (gen_request),
        .in_ready (gen_request_ready),
        .out_data (mem_request_out),
        .out_ready(mem_request_ready),
        .empty    (request_fifo_empty)
    );

    // ------------------------------
    // Output register and done
    // ------------------------------
    assign gen_result_ready = ~engine_out.valid | engine_out_ready;

    always_ff @(posedge ap_clk) begin
        if (reset_top) begin
            engine_out.valid <= 1'b0;
        end else if (gen_result.valid && gen_result_ready) begin
            engine_out <= gen_result;
        end else if (engine_out_ready) begin
            engine_out.valid <= 1'b0;
        end
    end

    // Nothing queued, walked, in flight or unsent
    always_ff @(posedge ap_clk) begin
        if (reset_top) begin
            done <= 1'b0;
        end else begin
            done <= csr_config.loaded & gen_idle & engine_fifo_empty
                    & request_fifo_empty & ~engine_out.valid;
        end
    end

endmodule

`default_nettype wire

// ==== verification/engine_csr_index_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module engine_csr_index_asserts import csr_packet_pkg::*; (
    input logic           ap_clk,
    input logic           areset_csr_engine,
    input mem_request_t   mem_request_out,
    input logic           mem_request_ready,
    input engine_packet_t engine_out,
    input logic           engine_out_ready,
    input logic           done
);

    int unsigned error_count = 0;

    // ------------------------------
    // Reset
    // ------------------------------
    // Two edges cover the registered reset copy
    reset_clears_outputs: assert property (@(posedge ap_clk)
        $past(areset_csr_engine, 2) |-> !mem_request_out.valid && !engine_out.valid && !done)
    else begin
        error_count++;
        $error("valid output or done high after reset");
    end

    // ------------------------------
    // Handshakes
    // ------------------------------
    request_held: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        mem_request_out.valid && !mem_request_ready |=> $stable(mem_request_out))
    else begin
        error_count++;
        $error("mem_request_out changed while stalled");
    end

    result_held: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        engine_out.valid && !engine_out_ready |=> $stable(engine_out))
    else begin
        error_count++;
        $error("engine_out changed while stalled");
    end

    // Done only once the request queue has drained
    done_after_requests: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        $rose(done) |-> !mem_request_out.valid)
    else begin
        error_count++;
        $error("done rose with a memory request pending");
    end

endmodule

bind engine_csr_index engine_csr_index_asserts u_asserts (
    .ap_clk           (ap_clk),
    .areset_csr_engine(areset_csr_engine),
    .mem_request_out  (mem_request_out),
    .mem_request_ready(mem_request_ready),
    .engine_out       (engine_out),
    .engine_out_ready (engine_out_ready),
    .done             (done)
);

`default_nettype wire

// ==== verification/tb_engine_csr_index.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_engine_csr_index import csr_config_pkg::*, csr_packet_pkg::*; ();

    localparam int num_cases = 14;
    localparam int clk_period = 100;
    localparam int reset_cycles = 16;
    localparam logic [31:0] seed = 32'h127930bc;

    // DUT ports
    logic           ap_clk;
    logic           areset_csr_engine = 1'b1;
    engine_packet_t engine_in = '0;
    logic           engine_in_ready;
    mem_response_t  mem_response_in = '0;
    logic           mem_response_ready;
    mem_request_t   mem_request_out;
    logic           mem_request_ready = 1'b0;
    engine_packet_t engine_out;
    logic           engine_out_ready = 1'b0;
    logic           done;

    // Case table with four words per line for base, stride, start and count
    logic [31:0] case_words [num_cases*4];

    // ------------------------------
    // Scoreboard state
    // ------------------------------
    mem_request_t   exp_req [$];
    mem_request_t   pending [$];
    engine_packet_t exp_res [$];
    mem_response_t  cfg_q [$];
    int             results_seen = 0;
    int             watchdog_cycles = 0;
    logic [31:0]    rng_state = seed;
    logic [31:0]    rnd;

    engine_csr_index #(
        .fifo_depth (fifo_depth_default),
        .prog_thresh(prog_thresh_default)
    ) uut (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .engine_in         (engine_in),
        .engine_in_ready   (engine_in_ready),
        .mem_response_in   (mem_response_in),
        .mem_response_ready(mem_response_ready),
        .mem_request_out   (mem_request_out),
        .mem_request_ready (mem_request_ready),
        .engine_out        (engine_out),
        .engine_out_ready  (engine_out_ready),
        .done              (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(clk_period / 2) ap_clk = ~ap_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Memory contents hashed from the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return xorshift32(addr ^ seed);
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic compare_request(input string name, input mem_request_t exp,
                                   input mem_request_t got);
        if (got !== exp) begin
            $display("FAILED %s: expected addr %h tag %h, got addr %h tag %h",
                     name, exp.addr, exp.tag, got.addr, got.tag);
            abort_run();
        end
    endtask

    task automatic compare_packet(input string name, input engine_packet_t exp,
                                  input engine_packet_t got);
        if (got !== exp) begin
            $display("FAILED %s: expected start %h count %h data %h, got start %h count %h data %h",
                     name, exp.start, exp.count, exp.data, got.start, got.count, got.data);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: expected %h, got %h", name, exp, got);
            abort_run();
        end
    endtask

    // Request must be the next one of the walked range
    task automatic take_request();
        mem_request_t exp;
        if (exp_req.size() == 0) begin
            $display("Memory request for addr %h arrived while none was expected",
                     mem_request_out.addr);
            abort_run();
        end else begin
            exp = exp_req.pop_front();
            compare_request("mem_request_out", exp, mem_request_out);
            pending.push_back(mem_request_out);
        end
    endtask

    // Results may come back in any order so they are matched by index
    task automatic take_result();
        engine_packet_t exp;
        int             hit;
        hit = -1;
        foreach (exp_res[i]) begin
            if (exp_res[i].start == engine_out.start) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            $display("Result for index %h matches no returned response", engine_out.start);
            abort_run();
        end else begin
            exp = exp_res[hit];
            exp_res.delete(hit);
            compare_packet("engine_out", exp, engine_out);
            results_seen++;
        end
    endtask

    // ------------------------------
    // Memory model and result monitor
    // ------------------------------
    always @(posedge ap_clk) begin : memory_model
        int             pick;
        mem_request_t   picked;
        mem_response_t  resp;
        engine_packet_t res;
        rnd = next_random();
        if (uut.u_asserts.error_count != 0) begin
            $display("A concurrent assertion on the DUT failed");
            abort_run();
        end
        // Done stays low while any issued read still owes a result
        if (done && (pending.size() != 0 || exp_res.size() != 0)) begin
            $display("done was high while reads or results were still outstanding");
            abort_run();
        end
        if (mem_request_out.valid && mem_request_ready) begin
            take_request();
        end
        if (engine_out.valid && engine_out_ready) begin
            take_result();
        end
        // Slot is free when idle or taken at this edge
        if (!mem_response_in.valid || mem_response_ready) begin
            if (cfg_q.size() != 0) begin
                mem_response_in <= cfg_q.pop_front();
            end else if (pending.size() != 0 && rnd[2:0] < 3'd3) begin
                // Random pick reorders and the skip chance adds delay
                pick = int'(rnd[31:16]) % pending.size();
                picked = pending[pick];
                pending.delete(pick);
                resp.valid = 1'b1;
                resp.dest = dest_generator;
                resp.tag = picked.tag;
                resp.data = mem_word(picked.addr);
                mem_response_in <= resp;
                res.valid = 1'b1;
                res.start = picked.tag;
                res.count = '0;
                res.data = resp.data;
                exp_res.push_back(res);
            end else begin
                mem_response_in.valid <= 1'b0;
            end
        end
        // Back-pressure on both outbound streams
        mem_request_ready <= rnd[3] | rnd[4];
        engine_out_ready <= rnd[5] | rnd[6];
    end

    task automatic apply_reset();
        areset_csr_engine <= 1'b1;
        repeat (reset_cycles) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;
        // Registered reset copies lag one cycle
        repeat (4) @(posedge ap_clk);
    endtask

    // Holds the packet until the engine FIFO takes it
    task automatic send_packet(input logic [15:0] start, input logic [15:0] count);
        engine_packet_t pkt;
        pkt.valid = 1'b1;
        pkt.start = start;
        pkt.count = count;
        pkt.data = '0;
        engine_in <= pkt;
        @(posedge ap_clk);
        while (!engine_in_ready) begin
            @(posedge ap_clk);
        end
        engine_in.valid <= 1'b0;
    endtask

    // Address of each element is base + index * stride
    task automatic queue_requests(input logic [31:0] base, input logic [15:0] stride,
                                  input logic [15:0] start, input logic [15:0] count);
        mem_request_t req;
        logic [31:0]  index;
        for (int i = 0; i < int'(count); i++) begin
            index = 32'(start) + 32'(i);
            req.valid = 1'b1;
            req.addr = base + index * 32'(stride);
            req.tag = index[15:0];
            exp_req.push_back(req);
        end
    endtask

    task automatic load_config(input logic [31:0] base, input logic [15:0] stride);
        mem_response_t word;
        word.valid = 1'b1;
        word.dest = dest_config;
        word.tag = config_tag_base;
        word.data = base;
        cfg_q.push_back(word);
        word.tag = config_tag_stride;
        word.data = {16'h0, stride};
        cfg_q.push_back(word);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : main_sequence
        logic [31:0] base;
        logic [15:0] stride;
        logic [15:0] start;
        logic [15:0] count;
        logic [31:0] cur_base;
        logic [15:0] cur_stride;
        logic        configured;
        int          total;
        int          seen_before;
        configured = 1'b0;
        cur_base = '0;
        cur_stride = '0;
        total = 0;
        $readmemh("verification/csr_index_cases.txt", case_words);
        for (int c = 0; c < num_cases; c++) begin
            total += int'(case_words[c*4+3][15:0]);
        end
        // 200 cycles per index plus reset and config time per case
        watchdog_cycles = total * 200 + num_cases * 100 + 1000;
        for (int c = 0; c < num_cases; c++) begin
            base = case_words[c*4];
            stride = case_words[c*4+1][15:0];
            start = case_words[c*4+2][15:0];
            count = case_words[c*4+3][15:0];
            seen_before = results_seen;
            if (!configured || base != cur_base || stride != cur_stride) begin
                // Config is permanent so a new one needs a reset
                apply_reset();
                compare_flag("done", done, 1'b0);
                // Packet waits unserved until both config words land
                send_packet(start, count);
                repeat (20) @(posedge ap_clk);
                compare_flag("done", done, 1'b0);
                queue_requests(base, stride, start, count);
                load_config(base, stride);
                cur_base = base;
                cur_stride = stride;
                configured = 1'b1;
            end else begin
                queue_requests(base, stride, start, count);
                send_packet(start, count);
                repeat (2) @(posedge ap_clk);
                compare_flag("done", done, 1'b0);
            end
            @(posedge ap_clk);
            while (!(done && (results_seen - seen_before) == int'(count))) begin
                @(posedge ap_clk);
            end
            if (exp_req.size() != 0 || pending.size() != 0 || exp_res.size() != 0) begin
                $display("Requests or results left over after case %0d", c);
                abort_run();
            end
        end
        if (uut.u_asserts.error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Concurrent assertions failed during the run");
            abort_run();
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge ap_clk);
        $display("Timeout after %0d cycles, the engine did not finish", watchdog_cycles);
        abort_run();
    end

endmodule

`default_nettype wire

// ==== verification/csr_index_cases.txt ====
// Columns: base address, element stride, start index, entry count (all hex)
// A change of base or stride means a reset and a fresh configuration
00001000 0004 0000 0008
00001000 0004 0010 0001
00001000 0004 0020 0028
00001000 0004 0005 0003
80000000 0010 0100 0010
80000000 0010 0000 0002
80000000 0010 fff0 000c
0000abc0 0008 1234 0020
0000abc0 0008 0000 0001
fffff000 0040 0007 0010
fffff000 0040 0100 0005
00000000 0001 0000 0030
00000000 0001 0040 0011
12345678 0003 7fff 0018

// ==== filelist.f ====
src/csr_config_pkg.sv
src/csr_packet_pkg.sv
src/csr_fifo.sv
src/csr_response_router.sv
src/csr_configure_memory.sv
src/csr_index_generator.sv
src/engine_csr_index.sv
verification/engine_csr_index_asserts.sv
verification/tb_engine_csr_index.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_engine_csr_index
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
